/* logic/uart_cfg_pkg.sv */
package uart_cfg_pkg;

  // bus data and divisor register width
  localparam int bus_width = 16;

  typedef enum logic [1:0] {
    reg_div    = 2'd0,  // divisor, read/write
    reg_txdata = 2'd1,  // write starts a frame
    reg_rxdata = 2'd2,  // read clears valid and overrun
    reg_status = 2'd3   // read clears framing error
  } reg_addr_e;

  typedef enum logic {
    cmd_read  = 1'b0,
    cmd_write = 1'b1
  } bus_cmd_e;

  // bit positions inside reg_status
  localparam int stat_tx_busy   = 0;
  localparam int stat_rx_valid  = 1;
  localparam int stat_overrun   = 2;
  localparam int stat_frame_err = 3;

endpackage

/* logic/uart_frame_pkg.sv */
package uart_frame_pkg;

  // oversampling ticks per bit
  localparam int os_ticks = 16;

  // ticks from the start edge to the start bit centre
  localparam int start_ticks = os_ticks / 2 - 1;

  typedef enum logic [1:0] {
    tx_st_idle,
    tx_st_start,
    tx_st_data,
    tx_st_stop
  } tx_state_e;

  typedef enum logic [1:0] {
    rx_st_idle,
    rx_st_start,
    rx_st_data,
    rx_st_stop
  } rx_state_e;

endpackage

/* logic/uart_baud_gen.sv */
`timescale 1ns/100ps

module uart_baud_gen
  (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [uart_cfg_pkg::bus_width-1:0] div,
    output logic                              s_tick
  );

  import uart_cfg_pkg::*;

  logic [bus_width-1:0] cnt;
  logic [bus_width-1:0] reload;

  assign reload = (div == '0) ? '0 : div - 1'b1;  // div of 0 acts as 1

  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
    begin
      cnt    <= '0;
      s_tick <= 1'b0;
    end
    else if (cnt == '0)
    begin
      cnt    <= reload;  // new divisor picked up here
      s_tick <= 1'b1;
    end
    else
    begin
      cnt    <= cnt - 1'b1;
      s_tick <= 1'b0;
    end
  end

  // a steady divisor above one never gives back-to-back ticks
  a_tick_spacing: assert property (@(posedge clk) disable iff (reset)
    (s_tick && div > 1 && $stable(div)) |=> !s_tick);

endmodule

/* logic/uart_tx.sv */
`timescale 1ns/100ps

module uart_tx
  #(
    parameter int dbit    = 8,
    parameter int sb_tick = 16
  )
  (
    input  logic            clk,
    input  logic            reset,
    input  logic            s_tick,
    input  logic            tx_start,
    input  logic [dbit-1:0] tx_data,
    output logic            tx,
    output logic            tx_busy
  );

  import uart_frame_pkg::*;

  localparam int max_ticks = (sb_tick > os_ticks) ? sb_tick : os_ticks;
  localparam int tick_w    = $clog2(max_ticks);
  localparam int bit_w     = (dbit > 1) ? $clog2(dbit) : 1;

  tx_state_e           state_reg, state_next;
  logic [tick_w-1:0]   tick_reg, tick_next;
  logic [bit_w-1:0]    nbit_reg, nbit_next;
  logic [dbit-1:0]     shift_reg, shift_next;
  logic                tx_reg, tx_next;

  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
    begin
      state_reg <= tx_st_idle;
      tick_reg  <= '0;
      nbit_reg  <= '0;
      tx_reg    <= 1'b1;  // line idles high
    end
    else
    begin
      state_reg <= state_next;
      tick_reg  <= tick_next;
      nbit_reg  <= nbit_next;
      tx_reg    <= tx_next;
    end
  end

  always_ff @(posedge clk)
  begin
    shift_reg <= shift_next;
  end

  always_comb
  begin
    state_next = state_reg;
    tick_next  = tick_reg;
    nbit_next  = nbit_reg;
    shift_next = shift_reg;
    tx_next    = tx_reg;
    case (state_reg)
      tx_st_idle:
      begin
        tx_next = 1'b1;
        if (tx_start)
        begin
          state_next = tx_st_start;
          tick_next  = '0;
          shift_next = tx_data;
        end
      end
      tx_st_start:
      begin
        tx_next = 1'b0;
        if (s_tick)
        begin
          if (tick_reg == tick_w'(os_ticks - 1))
          begin
            state_next = tx_st_data;
            tick_next  = '0;
            nbit_next  = '0;
          end
          else
            tick_next = tick_reg + 1'b1;
        end
      end
      tx_st_data:
      begin
        tx_next = shift_reg[0];  // lsb first
        if (s_tick)
        begin
          if (tick_reg == tick_w'(os_ticks - 1))
          begin
            tick_next  = '0;
            shift_next = shift_reg >> 1;
            if (nbit_reg == bit_w'(dbit - 1))
              state_next = tx_st_stop;
            else
              nbit_next = nbit_reg + 1'b1;
          end
          else
            tick_next = tick_reg + 1'b1;
        end
      end
      tx_st_stop:
      begin
        tx_next = 1'b1;
        if (s_tick)
        begin
          if (tick_reg == tick_w'(sb_tick - 1))
            state_next = tx_st_idle;
          else
            tick_next = tick_reg + 1'b1;
        end
      end
    endcase
  end

  assign tx      = tx_reg;
  assign tx_busy = (state_reg != tx_st_idle);

  a_idle_high: assert property (@(posedge clk) disable iff (reset)
    (state_reg == tx_st_idle) |-> tx);

endmodule

/* logic/uart_rx.sv */
`timescale 1ns/100ps

module uart_rx
  #(
    parameter int dbit = 8
  )
  (
    input  logic            clk,
    input  logic            reset,
    input  logic            s_tick,
    input  logic            rx,
    output logic            rx_done,
    output logic [dbit-1:0] rx_data,
    output logic            frame_err
  );

  import uart_frame_pkg::*;

  localparam int tick_w = $clog2(os_ticks);
  localparam int bit_w  = (dbit > 1) ? $clog2(dbit) : 1;

  rx_state_e         state_reg, state_next;
  logic [tick_w-1:0] tick_reg, tick_next;
  logic [bit_w-1:0]  nbit_reg, nbit_next;
  logic [dbit-1:0]   shift_reg, shift_next;
  logic              rx_meta, rx_sync, rx_last;
  logic              rx_fall;

  // two flop synchroniser plus one for edge detect
  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_last <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_last <= rx_sync;
    end
  end

  assign rx_fall = rx_last & ~rx_sync;

  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
    begin
      state_reg <= rx_st_idle;
      tick_reg  <= '0;
      nbit_reg  <= '0;
    end
    else
    begin
      state_reg <= state_next;
      tick_reg  <= tick_next;
      nbit_reg  <= nbit_next;
    end
  end

  always_ff @(posedge clk)
  begin
    shift_reg <= shift_next;
  end

  always_comb
  begin
    state_next = state_reg;
    tick_next  = tick_reg;
    nbit_next  = nbit_reg;
    shift_next = shift_reg;
    rx_done    = 1'b0;
    frame_err  = 1'b0;
    case (state_reg)
      rx_st_idle:
      begin
        if (rx_fall)
        begin
          state_next = rx_st_start;
          tick_next  = '0;
        end
      end
      rx_st_start:
      begin
        if (s_tick)
        begin
          if (tick_reg == tick_w'(start_ticks))
          begin
            tick_next = '0;
            nbit_next = '0;
            if (rx_sync)
              state_next = rx_st_idle;  // glitch, not a start bit
            else
              state_next = rx_st_data;
          end
          else
            tick_next = tick_reg + 1'b1;
        end
      end
      rx_st_data:
      begin
        if (s_tick)
        begin
          if (tick_reg == tick_w'(os_ticks - 1))
          begin
            tick_next  = '0;
            shift_next = {rx_sync, shift_reg[dbit-1:1]};
            if (nbit_reg == bit_w'(dbit - 1))
              state_next = rx_st_stop;
            else
              nbit_next = nbit_reg + 1'b1;
          end
          else
            tick_next = tick_reg + 1'b1;
        end
      end
      rx_st_stop:
      begin
        if (s_tick)
        begin
          if (tick_reg == tick_w'(os_ticks - 1))
          begin
            state_next = rx_st_idle;
            rx_done    = rx_sync;
            frame_err  = ~rx_sync;  // stop bit sampled low
          end
          else
            tick_next = tick_reg + 1'b1;
        end
      end
    endcase
  end

  assign rx_data = shift_reg;

  a_done_xor_err: assert property (@(posedge clk) disable iff (reset)
    !(rx_done && frame_err));

endmodule

/* logic/uart_regs.sv */
`timescale 1ns/100ps

module uart_regs
  #(
    parameter int dbit        = 8,
    parameter int default_div = 4
  )
  (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               req,
    input  uart_cfg_pkg::bus_cmd_e             cmd,
    input  uart_cfg_pkg::reg_addr_e            addr,
    input  logic [uart_cfg_pkg::bus_width-1:0] wdata,
    input  logic                               tx_busy,
    input  logic                               rx_done,
    input  logic [dbit-1:0]                    rx_data,
    input  logic                               frame_err,
    output logic                               ack,
    output logic [uart_cfg_pkg::bus_width-1:0] rdata,
    output logic [uart_cfg_pkg::bus_width-1:0] div,
    output logic                               tx_start,
    output logic [dbit-1:0]                    tx_data
  );

  import uart_cfg_pkg::*;

  typedef enum logic {wait_req, wait_release} bus_state_e;

  bus_state_e           state;
  logic                 access;
  logic                 rd_rx, rd_status, wr_tx;
  logic                 rx_valid, overrun, ferr_flag;
  logic [dbit-1:0]      rx_buf;
  logic [bus_width-1:0] status_word;

  assign access    = (state == wait_req) && req;  // once per handshake
  assign rd_rx     = access && cmd == cmd_read && addr == reg_rxdata;
  assign rd_status = access && cmd == cmd_read && addr == reg_status;
  assign wr_tx     = access && cmd == cmd_write && addr == reg_txdata;
  assign ack       = (state == wait_release);

  always_comb
  begin
    status_word                 = '0;
    status_word[stat_tx_busy]   = tx_busy;
    status_word[stat_rx_valid]  = rx_valid;
    status_word[stat_overrun]   = overrun;
    status_word[stat_frame_err] = ferr_flag;
  end

  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
    begin
      state     <= wait_req;
      div       <= bus_width'(default_div);
      tx_start  <= 1'b0;
      rx_valid  <= 1'b0;
      overrun   <= 1'b0;
      ferr_flag <= 1'b0;
    end
    else
    begin
      case (state)
        wait_req:     if (req) state <= wait_release;
        wait_release: if (!req) state <= wait_req;
      endcase
      tx_start <= wr_tx;
      if (access && cmd == cmd_write && addr == reg_div)
        div <= wdata;
      if (rd_rx)
      begin
        rx_valid <= 1'b0;
        overrun  <= 1'b0;
      end
      if (rx_done)
      begin
        if (rx_valid && !rd_rx)
          overrun <= 1'b1;  // old byte kept
        else
          rx_valid <= 1'b1;
      end
      if (rd_status)
        ferr_flag <= 1'b0;
      if (frame_err)
        ferr_flag <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_tx)
      tx_data <= wdata[dbit-1:0];
    if (rx_done && (!rx_valid || rd_rx))
      rx_buf <= rx_data;
    if (access && cmd == cmd_read)
    begin
      case (addr)
        reg_div:    rdata <= div;
        reg_rxdata: rdata <= bus_width'(rx_buf);
        reg_status: rdata <= status_word;
        default:    rdata <= '0;  // txdata is write-only
      endcase
    end
  end

  // ack rises on the edge that saw req high
  a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(ack) |-> $past(req));

endmodule

/* logic/uart_top.sv */
`timescale 1ns/100ps

module uart_top
  #(
    parameter int dbit        = 8,
    parameter int sb_tick     = 16,
    parameter int default_div = 4
  )
  (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               req,
    input  uart_cfg_pkg::bus_cmd_e             cmd,
    input  uart_cfg_pkg::reg_addr_e            addr,
    input  logic [uart_cfg_pkg::bus_width-1:0] wdata,
    output logic                               ack,
    output logic [uart_cfg_pkg::bus_width-1:0] rdata,
    input  logic                               rx,
    output logic                               tx
  );

  import uart_cfg_pkg::*;

  logic [bus_width-1:0] div;
  logic                 s_tick;
  logic                 tx_start, tx_busy;
  logic [dbit-1:0]      tx_data, rx_data;
  logic                 rx_done, frame_err;

  uart_regs #(.dbit(dbit), .default_div(default_div)) regs_i
  (
    .clk(clk), .reset(reset), .req(req), .cmd(cmd), .addr(addr), .wdata(wdata),
    .tx_busy(tx_busy), .rx_done(rx_done), .rx_data(rx_data), .frame_err(frame_err),
    .ack(ack), .rdata(rdata), .div(div), .tx_start(tx_start), .tx_data(tx_data)
  );

  uart_baud_gen baud_i (.clk(clk), .reset(reset), .div(div), .s_tick(s_tick));

  uart_tx #(.dbit(dbit), .sb_tick(sb_tick)) tx_i
  (
    .clk(clk), .reset(reset), .s_tick(s_tick), .tx_start(tx_start),
    .tx_data(tx_data), .tx(tx), .tx_busy(tx_busy)
  );

  uart_rx #(.dbit(dbit)) rx_i
  (
    .clk(clk), .reset(reset), .s_tick(s_tick), .rx(rx),
    .rx_done(rx_done), .rx_data(rx_data), .frame_err(frame_err)
  );

endmodule

/* verif/uart_tb_tasks.svh */
// one four-phase handshake per call
task automatic bus_cycle(input bus_cmd_e c, input reg_addr_e a,
                         input logic [bus_width-1:0] d,
                         output logic [bus_width-1:0] q);
  int n;
  @(negedge clk);
  assert (!ack) else
  begin
    $display("bus handshake: ack was high before req rose");
    errors++;
  end
  cmd   = c;
  addr  = a;
  wdata = d;
  req   = 1'b1;
  n     = 0;
  while (!ack && n < 20)
  begin
    @(negedge clk);
    n++;
  end
  assert (ack) else
  begin
    $display("bus handshake: no ack within 20 cycles");
    errors++;
  end
  q   = rdata;  // valid while ack is high
  req = 1'b0;
  n   = 0;
  while (ack && n < 20)
  begin
    @(negedge clk);
    n++;
  end
  assert (!ack) else
  begin
    $display("bus handshake: ack stayed high after req fell");
    errors++;
  end
endtask

task automatic bus_write(input reg_addr_e a, input logic [bus_width-1:0] d);
  logic [bus_width-1:0] unused_q;
  bus_cycle(cmd_write, a, d, unused_q);
endtask

task automatic bus_read(input reg_addr_e a, output logic [bus_width-1:0] q);
  bus_cycle(cmd_read, a, '0, q);
endtask

task automatic compare_word(input string test, input logic [bus_width-1:0] exp,
                            input logic [bus_width-1:0] act);
  assert (act === exp) else
  begin
    $display("[FAIL] %s: expected %h, actual %h", test, exp, act);
    errors++;
  end
endtask

task automatic poll_status(input int pos, input logic level, input string test,
                           output logic [bus_width-1:0] st);
  int n;
  n = 0;
  bus_read(reg_status, st);
  while (st[pos] !== level && n < 20 * os_ticks * cur_div)
  begin
    bus_read(reg_status, st);
    n++;
  end
  assert (st[pos] === level) else
  begin
    $display("%s: status bit %0d never reached %b", test, pos, level);
    errors++;
  end
endtask

// start bit, data lsb first, then the given stop level
task automatic send_serial(input logic [dbit-1:0] data, input logic stop_bit);
  logic [dbit+1:0] frame;
  frame = {stop_bit, data, 1'b0};
  for (int i = 0; i < dbit + 2; i++)
  begin
    @(negedge clk);
    rx = frame[i];
    repeat (os_ticks * cur_div - 1) @(negedge clk);
  end
  @(negedge clk);
  rx = 1'b1;
endtask

task automatic recv_serial(output logic [dbit-1:0] data, output logic stop_bit);
  int n;
  n = 0;
  while (tx !== 1'b0 && n < 4 * os_ticks * max_div)
  begin
    @(negedge clk);
    n++;
  end
  assert (tx === 1'b0) else
  begin
    $display("serial monitor: no start bit seen on tx");
    errors++;
  end
  repeat (os_ticks * cur_div / 2) @(negedge clk);  // centre of start bit
  for (int i = 0; i < dbit; i++)
  begin
    repeat (os_ticks * cur_div) @(negedge clk);
    data[i] = tx;
  end
  repeat (os_ticks * cur_div) @(negedge clk);
  stop_bit = tx;
endtask

task automatic check_line_idle(input string test, input int cycles);
  int lows;
  lows = 0;
  repeat (cycles)
  begin
    @(negedge clk);
    if (tx !== 1'b1)
      lows++;
  end
  assert (lows == 0) else
  begin
    $display("%s: tx left idle high for %0d cycles", test, lows);
    errors++;
  end
endtask

task automatic reset_values();
  logic [bus_width-1:0] q;
  bus_read(reg_div, q);
  compare_word("reset divisor", bus_width'(default_div), q);
  bus_read(reg_status, q);
  compare_word("reset status", '0, q);
  compare_word("reset tx line", bus_width'(1), bus_width'(tx));
endtask

task automatic divisor_rw();
  logic [bus_width-1:0] val, q;
  val = bus_width'($random(seed)) & bus_width'(max_div);
  bus_write(reg_div, val);
  bus_read(reg_div, q);
  compare_word("divisor access", val, q);
  bus_write(reg_div, bus_width'(default_div));
  repeat (max_div + 2) @(negedge clk);  // old divisor has to wrap once
endtask

task automatic transmit_frames();
  logic [bus_width-1:0] st;
  logic [dbit-1:0]      b, got;
  logic                 stop;
  bus_write(reg_div, bus_width'(2));
  cur_div = 2;
  repeat (3)
  begin
    poll_status(stat_tx_busy, 1'b0, "transmit", st);
    b = dbit'($random(seed));
    bus_write(reg_txdata, bus_width'(b));
    recv_serial(got, stop);
    compare_word("transmit byte", bus_width'(b), bus_width'(got));
    compare_word("transmit stop bit", bus_width'(1), bus_width'(stop));
  end
  poll_status(stat_tx_busy, 1'b0, "transmit", st);
  b = dbit'($random(seed));
  fork
    recv_serial(got, stop);
    begin
      bus_write(reg_txdata, bus_width'(b));
      bus_read(reg_status, st);
      compare_word("busy during frame", bus_width'(1), bus_width'(st[stat_tx_busy]));
      bus_write(reg_txdata, bus_width'(~b));  // must be dropped
    end
  join
  compare_word("dropped write", bus_width'(b), bus_width'(got));
  poll_status(stat_tx_busy, 1'b0, "dropped write", st);
  check_line_idle("dropped write", 12 * os_ticks * cur_div);
endtask

task automatic receive_frame();
  logic [bus_width-1:0] st, q;
  logic [dbit-1:0]      b;
  b = dbit'($random(seed));
  send_serial(b, 1'b1);
  poll_status(stat_rx_valid, 1'b1, "receive", st);
  bus_read(reg_rxdata, q);
  compare_word("receive byte", bus_width'(b), q);
  bus_read(reg_status, st);
  compare_word("receive valid cleared", '0, bus_width'(st[stat_rx_valid]));
endtask

task automatic overrun_check();
  logic [bus_width-1:0] st, q;
  logic [dbit-1:0]      b1, b2;
  b1 = dbit'($random(seed));
  b2 = dbit'($random(seed));
  send_serial(b1, 1'b1);
  send_serial(b2, 1'b1);
  poll_status(stat_overrun, 1'b1, "overrun", st);
  compare_word("overrun status", bus_width'((1 << stat_rx_valid) | (1 << stat_overrun)), st);
  bus_read(reg_rxdata, q);
  compare_word("overrun keeps first byte", bus_width'(b1), q);
  bus_read(reg_status, st);
  compare_word("overrun cleared", '0, st);
endtask

task automatic framing_check();
  logic [bus_width-1:0] st;
  logic [dbit-1:0]      b;
  b = dbit'($random(seed));
  send_serial(b, 1'b0);  // stop bit held low
  poll_status(stat_frame_err, 1'b1, "framing error", st);
  compare_word("framing error status", bus_width'(1 << stat_frame_err), st);
  bus_read(reg_status, st);
  compare_word("framing error cleared", '0, st);
endtask

/* verif/uart_tb.sv */
`timescale 1ns/100ps

module uart_tb;

  import uart_cfg_pkg::*;
  import uart_frame_pkg::*;

  localparam int dbit        = 8;
  localparam int sb_tick     = 16;
  localparam int default_div = 4;
  localparam int max_div     = 255;  // largest divisor the tests write
  localparam int n_frames    = 8;
  localparam int watchdog_ns = n_frames * 10 * os_ticks * max_div * 10 * 2;

  logic                 clk;
  logic                 reset;
  logic                 req;
  bus_cmd_e             cmd;
  reg_addr_e            addr;
  logic [bus_width-1:0] wdata;
  logic                 ack;
  logic [bus_width-1:0] rdata;
  logic                 rx;
  logic                 tx;

  int errors;
  int seed;
  int cur_div;  // divisor the serial tasks time their bits with

  uart_top #(.dbit(dbit), .sb_tick(sb_tick), .default_div(default_div)) UUT
  (
    .clk(clk), .reset(reset), .req(req), .cmd(cmd), .addr(addr), .wdata(wdata),
    .ack(ack), .rdata(rdata), .rx(rx), .tx(tx)
  );

  `include "uart_tb_tasks.svh"

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial
  begin
    #(watchdog_ns);
    $display("watchdog expired before the test sequence finished");
    $display("Something failed");
    $finish;
  end

  initial
  begin
    errors  = 0;
    seed    = 72105;
    cur_div = default_div;
    reset   = 1'b1;
    req     = 1'b0;
    cmd     = cmd_read;
    addr    = reg_div;
    wdata   = '0;
    rx      = 1'b1;  // serial line idles high
    repeat (2) @(negedge clk);
    reset = 1'b0;
    reset_values();
    divisor_rw();
    transmit_frames();
    receive_frame();
    overrun_check();
    framing_check();
    $display("tests done, errors: %0d", errors);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

/* files.f */
+incdir+verif
logic/uart_cfg_pkg.sv
logic/uart_frame_pkg.sv
logic/uart_baud_gen.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_regs.sv
logic/uart_top.sv
verif/uart_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module uart_tb -o uart_sim &&
./obj_dir/uart_sim | tee /dev/stderr | grep -qx "Everything OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
